/* rtl/sdma_burst_writer.sv */
module sdma_burst_writer (
    input  logic            clock,
    input  logic            reset,
    input  logic            burst_start,
    input  sdma_pkg::addr_t burst_addr,
    input  sdma_pkg::word_t fifo_data,
    output logic            fifo_rd,
    output logic            burst_done,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output sdma_pkg::addr_t wb_adr,
    output sdma_pkg::word_t wb_dat_o,
    output logic [3:0]      wb_sel,
    input  logic            wb_ack
);
    import sdma_pkg::*;

    localparam int CNT_W = $clog2(BURST_WORDS);

    typedef enum logic [1:0] {
        wr_idle,
        wr_load,
        wr_strobe
    } wr_state_t;

    wr_state_t        state;
    logic [CNT_W-1:0] word_cnt;
    logic             open_burst;
    logic             last_word;

    assign open_burst = (state == wr_idle) && burst_start;
    assign last_word  = (word_cnt == CNT_W'(BURST_WORDS - 1));

    // Pop the head word whenever it is taken into the data register
    assign fifo_rd = open_burst || (state == wr_load);

    // Full-word writes only
    assign wb_we  = 1'b1;
    assign wb_sel = 4'hf;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone classic handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= wr_idle;
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            burst_done <= 1'b0;
            word_cnt   <= '0;
        end else begin
            burst_done <= 1'b0;
            case (state)
                wr_idle: begin
                    if (burst_start) begin
                        wb_cyc   <= 1'b1;
                        wb_stb   <= 1'b1;
                        word_cnt <= '0;
                        state    <= wr_strobe;
                    end
                end
                wr_strobe: begin
                    if (wb_ack) begin
                        wb_stb <= 1'b0;
                        if (last_word) begin
                            wb_cyc     <= 1'b0;
                            burst_done <= 1'b1;
                            state      <= wr_idle;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= wr_load;
                        end
                    end
                end
                // Strobe is low for this cycle while the next word loads
                wr_load: begin
                    wb_stb <= 1'b1;
                    state  <= wr_strobe;
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // Address and data, held until ack
    always_ff @(posedge clock) begin
        if (fifo_rd) begin
            wb_dat_o <= fifo_data;
        end
        if (open_burst) begin
            wb_adr <= burst_addr;
        end else if ((state == wr_strobe) && wb_ack) begin
            wb_adr <= wb_adr + addr_t'(4);
        end
    end

    stb_inside_cyc: assert property (@(posedge clock) disable iff (!reset)
        wb_stb |-> wb_cyc);

    no_start_in_burst: assert property (@(posedge clock) disable iff (!reset)
        burst_start |-> !wb_cyc && (state == wr_idle));

endmodule

/* rtl/sdma_pkg.sv */
package sdma_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////////////

    // Card stream, FIFO and Wishbone data word
    typedef logic [31:0] word_t;

    // System byte address
    typedef logic [31:0] addr_t;

    // Block counts (programmed, transferred, within boundary)
    typedef logic [15:0] blkcnt_t;

    // SDMA buffer boundary code, 4 KiB << code
    typedef logic [2:0] boundary_t;

    // Bit 1 boundary, bit 0 transfer complete
    typedef logic [1:0] irq_t;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        wait_data,
        burst,
        block_check,
        boundary_pause,
        complete
    } seq_state_t;

    // Transfer geometry
    localparam int BURST_WORDS = 16;
    localparam int BLOCK_WORDS = 128;
    localparam int BURST_BYTES = 64;

endpackage

/* rtl/sdma_sequencer.sv */
module sdma_sequencer #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                start,
    input  sdma_pkg::addr_t                     sys_addr,
    input  logic                                sys_addr_load,
    input  sdma_pkg::boundary_t                 buf_boundary,
    input  sdma_pkg::blkcnt_t                   block_count,
    input  logic                                blk_count_ena,
    input  logic                                int_clear,
    input  logic [$clog2(FIFO_DEPTH + 1) - 1:0] fifo_level,
    input  logic                                burst_done,
    output logic                                fifo_flush,
    output logic                                burst_start,
    output sdma_pkg::addr_t                     burst_addr,
    output sdma_pkg::irq_t                      dma_interrupts,
    output logic                                busy
);
    import sdma_pkg::*;

    localparam int LEVEL_W          = $clog2(FIFO_DEPTH + 1);
    localparam int BURSTS_PER_BLOCK = BLOCK_WORDS / BURST_WORDS;
    localparam int BCNT_W           = $clog2(BURSTS_PER_BLOCK);

    seq_state_t        state;
    boundary_t         boundary_q;
    blkcnt_t           block_count_q;
    logic              count_ena_q;
    blkcnt_t           total_blk;
    blkcnt_t           bound_blk;
    blkcnt_t           bound_limit;
    logic [BCNT_W-1:0] burst_cnt;
    logic              burst_ready;
    logic              last_burst;
    logic              xfer_done;
    logic              bound_hit;

    // Boundary in blocks: 4 KiB << code is 8 << code blocks of 512 bytes
    assign bound_limit = blkcnt_t'(8) << boundary_q;

    // Level is stale in the cycle the flush is pending
    assign burst_ready = !fifo_flush && (fifo_level >= LEVEL_W'(BURST_WORDS));
    assign last_burst  = (burst_cnt == BCNT_W'(BURSTS_PER_BLOCK - 1));
    assign xfer_done   = count_ena_q && (total_blk == block_count_q);
    assign bound_hit   = (bound_blk == bound_limit);

    ////////////////////////////////////////////////////////////////////////////
    // Transfer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= idle;
            fifo_flush     <= 1'b0;
            burst_start    <= 1'b0;
            busy           <= 1'b0;
            dma_interrupts <= '0;
            total_blk      <= '0;
            bound_blk      <= '0;
            burst_cnt      <= '0;
        end else begin
            fifo_flush  <= 1'b0;
            burst_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        fifo_flush <= 1'b1;
                        busy       <= 1'b1;
                        total_blk  <= '0;
                        bound_blk  <= '0;
                        burst_cnt  <= '0;
                        state      <= wait_data;
                    end
                end
                wait_data: begin
                    if (burst_ready) begin
                        burst_start <= 1'b1;
                        state       <= burst;
                    end
                end
                burst: begin
                    if (burst_done) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        if (last_burst) begin
                            total_blk <= total_blk + 1'b1;
                            bound_blk <= bound_blk + 1'b1;
                            state     <= block_check;
                        end else begin
                            state <= wait_data;
                        end
                    end
                end
                // Completion takes priority over a boundary on the last block
                block_check: begin
                    if (xfer_done) begin
                        dma_interrupts[0] <= 1'b1;
                        state             <= complete;
                    end else if (bound_hit) begin
                        dma_interrupts[1] <= 1'b1;
                        state             <= boundary_pause;
                    end else begin
                        state <= wait_data;
                    end
                end
                boundary_pause: begin
                    if (sys_addr_load) begin
                        bound_blk <= '0;
                        state     <= wait_data;
                    end
                end
                complete: begin
                    busy  <= 1'b0;
                    state <= idle;
                end
                default: state <= idle;
            endcase
            if (int_clear) begin
                dma_interrupts <= '0;
            end
        end
    end

    // Programmed values and the running system address
    always_ff @(posedge clock) begin
        if ((state == idle) && start) begin
            burst_addr    <= sys_addr;
            boundary_q    <= buf_boundary;
            block_count_q <= block_count;
            count_ena_q   <= blk_count_ena;
        end else if ((state == burst) && burst_done) begin
            burst_addr <= burst_addr + addr_t'(BURST_BYTES);
        end else if ((state == boundary_pause) && sys_addr_load) begin
            burst_addr <= sys_addr;
        end
    end

    // The full burst is still in the FIFO when the writer is started
    burst_from_wait_data: assert property (@(posedge clock) disable iff (!reset)
        burst_start |-> $past(state == wait_data)
                        && (fifo_level >= LEVEL_W'(BURST_WORDS)));

endmodule

/* rtl/sdma_top.sv */
module sdma_top #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                clock,
    input  logic                reset,
    input  sdma_pkg::word_t     card_data,
    input  logic                card_valid,
    output logic                card_ready,
    input  logic                start,
    input  sdma_pkg::addr_t     sys_addr,
    input  logic                sys_addr_load,
    input  sdma_pkg::boundary_t buf_boundary,
    input  sdma_pkg::blkcnt_t   block_count,
    input  logic                blk_count_ena,
    input  logic                int_clear,
    output sdma_pkg::irq_t      dma_interrupts,
    output logic                busy,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output sdma_pkg::addr_t     wb_adr,
    output sdma_pkg::word_t     wb_dat_o,
    output logic [3:0]          wb_sel,
    input  logic                wb_ack
);
    import sdma_pkg::*;

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    // FIFO to writer
    word_t              fifo_data;
    logic               fifo_rd;
    logic [LEVEL_W-1:0] fifo_level;

    // Sequencer control
    logic               fifo_flush;
    logic               burst_start;
    addr_t              burst_addr;
    logic               burst_done;

    sdma_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdma_word_fifo_inst (
        .clock      (clock),
        .reset      (reset),
        .fifo_flush (fifo_flush),
        .card_data  (card_data),
        .card_valid (card_valid),
        .card_ready (card_ready),
        .fifo_rd    (fifo_rd),
        .fifo_data  (fifo_data),
        .fifo_level (fifo_level)
    );

    sdma_burst_writer sdma_burst_writer_inst (
        .clock       (clock),
        .reset       (reset),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .fifo_data   (fifo_data),
        .fifo_rd     (fifo_rd),
        .burst_done  (burst_done),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_ack      (wb_ack)
    );

    sdma_sequencer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdma_sequencer_inst (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .sys_addr       (sys_addr),
        .sys_addr_load  (sys_addr_load),
        .buf_boundary   (buf_boundary),
        .block_count    (block_count),
        .blk_count_ena  (blk_count_ena),
        .int_clear      (int_clear),
        .fifo_level     (fifo_level),
        .burst_done     (burst_done),
        .fifo_flush     (fifo_flush),
        .burst_start    (burst_start),
        .burst_addr     (burst_addr),
        .dma_interrupts (dma_interrupts),
        .busy           (busy)
    );

endmodule

/* rtl/sdma_word_fifo.sv */
module sdma_word_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               fifo_flush,
    input  sdma_pkg::word_t                    card_data,
    input  logic                               card_valid,
    output logic                               card_ready,
    input  logic                               fifo_rd,
    output sdma_pkg::word_t                    fifo_data,
    output logic [$clog2(FIFO_DEPTH + 1) - 1:0] fifo_level
);
    import sdma_pkg::*;

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    word_t              mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LEVEL_W-1:0] count;
    logic               push;

    // Hold the card off while full or while being emptied
    assign card_ready = (count != LEVEL_W'(FIFO_DEPTH)) && !fifo_flush;
    assign push       = card_valid && card_ready;
    assign fifo_data  = mem[rd_ptr];
    assign fifo_level = count;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= card_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock) begin
        if (!reset || fifo_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, fifo_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_read_when_empty: assert property (@(posedge clock) disable iff (!reset)
        fifo_rd |-> count != '0);

    // A write never lands on the slot of an unread word
    no_write_when_full: assert property (@(posedge clock) disable iff (!reset)
        push |-> (count == '0) || (wr_ptr != rd_ptr));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the SDMA testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module sdma_tb -o sdma_tb_sim \
    || { echo "Verilator build failed"; exit 1; }

output=$(./obj_dir/sdma_tb_sim)
echo "$output"

echo "$output" | grep -qxF "=== PASS ===" && exit 0 || exit 1

/* test/sdma_tb.sv */
module sdma_tb;
    import sdma_pkg::*;

    localparam int SEED        = 32'h0fc1_b4cb;
    localparam int TOTAL_WORDS = (1 + 3 + 10 + 1) * BLOCK_WORDS;
    localparam int IDLE_LIMIT  = 4000;

    logic       clock;
    logic       reset;
    word_t      card_data;
    logic       card_valid;
    logic       card_ready;
    logic       start;
    addr_t      sys_addr;
    logic       sys_addr_load;
    boundary_t  buf_boundary;
    blkcnt_t    block_count;
    logic       blk_count_ena;
    logic       int_clear;
    irq_t       dma_interrupts;
    logic       busy;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    word_t      wb_dat_o;
    logic [3:0] wb_sel;
    logic       wb_ack;

    int    seed = SEED;
    int    value_errors = 0;
    int    other_errors = 0;
    string test_name = "none";
    addr_t base_addr;
    addr_t second_addr;
    int    limit_blocks;
    int    word_idx;
    word_t sent_q [$];

    sdma_top #(
        .FIFO_DEPTH (32)
    ) sdma_top_inst (
        .clock          (clock),
        .reset          (reset),
        .card_data      (card_data),
        .card_valid     (card_valid),
        .card_ready     (card_ready),
        .start          (start),
        .sys_addr       (sys_addr),
        .sys_addr_load  (sys_addr_load),
        .buf_boundary   (buf_boundary),
        .block_count    (block_count),
        .blk_count_ena  (blk_count_ena),
        .int_clear      (int_clear),
        .dma_interrupts (dma_interrupts),
        .busy           (busy),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_o       (wb_dat_o),
        .wb_sel         (wb_sel),
        .wb_ack         (wb_ack)
    );

    wb_memory_model #(
        .SEED (SEED)
    ) memory_inst (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // Byte address of word n, second buffer starts after the boundary limit
    function automatic addr_t expected_addr(input int n, input addr_t base,
                                            input addr_t second, input int limit);
        if (n < limit * BLOCK_WORDS) begin
            return base + addr_t'(4 * n);
        end else begin
            return second + addr_t'(4 * (n - limit * BLOCK_WORDS));
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    initial begin : compare_writes
        addr_t got_addr;
        word_t got_data;
        word_t exp_data;
        forever begin
            @(negedge clock);
            while (memory_inst.write_addr.size() > 0) begin
                got_addr = memory_inst.write_addr.pop_front();
                got_data = memory_inst.write_data.pop_front();
                if (sent_q.size() == 0) begin
                    other_errors++;
                    $display("[%s] write to %h without a word from the card",
                             test_name, got_addr);
                end else begin
                    exp_data = sent_q.pop_front();
                    check_value($sformatf("word %0d address", word_idx),
                                expected_addr(word_idx, base_addr, second_addr,
                                              limit_blocks),
                                got_addr);
                    check_value($sformatf("word %0d data", word_idx), exp_data, got_data);
                end
                word_idx++;
            end
        end
    end

    // Every strobe is a full-word write
    always @(negedge clock) begin
        if (reset && wb_cyc && wb_stb) begin
            check_value("wb_sel", 32'hf, 32'(wb_sel));
            check_value("wb_we", 32'h1, 32'(wb_we));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Card holds each word until the FIFO takes it
    task automatic push_words(input int count, input int max_idle);
        int i;
        int idle;
        for (i = 0; i < count; i++) begin
            card_data  = $random(seed);
            card_valid = 1'b1;
            while (!card_ready) @(negedge clock);
            sent_q.push_back(card_data);
            @(negedge clock);
            card_valid = 1'b0;
            idle = ($random(seed) & 32'h7fff_ffff) % (max_idle + 1);
            repeat (idle) @(negedge clock);
        end
    endtask

    task automatic service_boundary(input addr_t second);
        int written;
        int busy_cycles;
        busy_cycles = 0;
        while (!dma_interrupts[1]) @(negedge clock);
        @(negedge clock);
        written = word_idx;
        check_value("words before boundary", limit_blocks * BLOCK_WORDS, written);
        check_value("dma_interrupts in pause", 32'h2, 32'(dma_interrupts));
        // Card keeps pushing, so the FIFO fills up here
        repeat (100) begin
            @(negedge clock);
            if (wb_cyc) begin
                busy_cycles++;
            end
        end
        assert (busy_cycles == 0 && word_idx == written) else begin
            other_errors++;
            $display("[%s] Wishbone write during the boundary pause", test_name);
        end
        sys_addr      = second;
        sys_addr_load = 1'b1;
        @(negedge clock);
        sys_addr_load = 1'b0;
    endtask

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        assert (!busy) else begin
            other_errors++;
            $display("[%s] transfer still busy after %0d cycles", test_name, IDLE_LIMIT);
        end
    endtask

    task automatic run_transfer(input string name, input addr_t base, input boundary_t code,
                                input int blocks, input addr_t second, input int max_idle);
        int total;
        total        = blocks * BLOCK_WORDS;
        test_name    = name;
        base_addr    = base;
        second_addr  = second;
        limit_blocks = 8 << code;
        word_idx     = 0;
        sent_q.delete();
        @(negedge clock);
        sys_addr      = base;
        buf_boundary  = code;
        block_count   = blkcnt_t'(blocks);
        blk_count_ena = 1'b1;
        start         = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_value("busy after start", 32'h1, 32'(busy));
        fork
            push_words(total, max_idle);
            if (limit_blocks < blocks) begin
                service_boundary(second);
            end
        join
        wait_until_idle();
        repeat (2) @(negedge clock);
        check_value("words written", total, word_idx);
        check_value("words never written", 0, sent_q.size());
    endtask

    task automatic clear_interrupts();
        @(negedge clock);
        int_clear = 1'b1;
        @(negedge clock);
        int_clear = 1'b0;
        check_value("dma_interrupts after clear", 32'h0, 32'(dma_interrupts));
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b0;
        card_data     = '0;
        card_valid    = 1'b0;
        start         = 1'b0;
        sys_addr      = '0;
        sys_addr_load = 1'b0;
        buf_boundary  = '0;
        block_count   = '0;
        blk_count_ena = 1'b0;
        int_clear     = 1'b0;
        repeat (10) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        test_name = "after_reset";
        check_value("wb_cyc", 32'h0, 32'(wb_cyc));
        check_value("busy", 32'h0, 32'(busy));
        check_value("dma_interrupts", 32'h0, 32'(dma_interrupts));
        check_value("card_ready", 32'h1, 32'(card_ready));

        run_transfer("single_block", 32'h0001_0000, 3'd7, 1, 32'h0, 2);
        check_value("dma_interrupts", 32'h1, 32'(dma_interrupts));
        clear_interrupts();

        // No idle cycles on the card, acks are the bottleneck
        run_transfer("three_blocks_fast_card", 32'h0002_0400, 3'd7, 3, 32'h0, 0);
        check_value("dma_interrupts", 32'h1, 32'(dma_interrupts));
        clear_interrupts();

        // 4 KiB boundary, 8 blocks then a new address
        run_transfer("boundary_pause", 32'h0003_0000, 3'd0, 10, 32'h0008_0000, 1);
        check_value("dma_interrupts", 32'h3, 32'(dma_interrupts));

        test_name = "int_clear";
        clear_interrupts();
        run_transfer("restart_after_clear", 32'h0004_0000, 3'd2, 1, 32'h0, 2);
        check_value("dma_interrupts", 32'h1, 32'(dma_interrupts));

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Bounded by 20 cycles per word plus some slack
    initial begin : watchdog
        repeat (TOTAL_WORDS * 20 + 2000) @(posedge clock);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* test/wb_memory_model.sv */
module wb_memory_model #(
    parameter int SEED = 1
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  sdma_pkg::addr_t wb_adr,
    input  sdma_pkg::word_t wb_dat_i,
    output logic            wb_ack
);
    import sdma_pkg::*;

    // Write log, drained by the testbench
    addr_t write_addr [$];
    word_t write_data [$];

    int   seed;
    int   delay;
    int   stall;
    logic counting;

    initial seed = SEED;

    task automatic log_write();
        if (wb_we) begin
            write_addr.push_back(wb_adr);
            write_data.push_back(wb_dat_i);
        end
    endtask

    // One ack per strobe, after 0 to 3 random wait cycles
    always @(posedge clock) begin
        if (!reset) begin
            wb_ack   <= 1'b0;
            counting <= 1'b0;
            stall    <= 0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!counting) begin
                    delay = $random(seed) & 3;
                    if (delay == 0) begin
                        wb_ack <= 1'b1;
                        log_write();
                    end else begin
                        counting <= 1'b1;
                        stall    <= delay;
                    end
                end else if (stall == 1) begin
                    wb_ack   <= 1'b1;
                    counting <= 1'b0;
                    log_write();
                end else begin
                    stall <= stall - 1;
                end
            end
        end
    end

endmodule

/* vlog.f */
rtl/sdma_pkg.sv
rtl/sdma_word_fifo.sv
rtl/sdma_burst_writer.sv
rtl/sdma_sequencer.sv
rtl/sdma_top.sv
test/wb_memory_model.sv
test/sdma_tb.sv
